//--- design/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath and memory sizes
`define CORE_XLEN        32
`define CORE_NREGS       16
`define CORE_IMEM_DEPTH  64
`define CORE_DMEM_DEPTH  64

// Word address of the trap handler
`define CORE_TRAP_VECTOR 48

// CSR numbers, taken from the low 12 immediate bits
`define CSR_MSTATUS      12'h000
`define CSR_MEPC         12'h001
`define CSR_MCAUSE       12'h002
`define CSR_MINSTRET     12'h003

`endif

//--- design/core_pkg.sv
package core_pkg;

    // Major opcodes, bits 31..28 of the instruction word
    typedef enum logic [3:0] {
        OP_ADD    = 4'h0,
        OP_SUB    = 4'h1,
        OP_ADDI   = 4'h2,
        OP_SLL    = 4'h3,
        OP_LW     = 4'h4,
        OP_SW     = 4'h5,
        OP_AMOADD = 4'h6,
        OP_CSRR   = 4'h7,
        OP_CSRW   = 4'h8
    } opcode_e;

    // Instruction class as seen by the phase FSM
    typedef enum logic [1:0] {
        CTRL_EXEC,
        CTRL_MEM,
        CTRL_AMO
    } ctrl_path_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [1:0] {
        CAUSE_NONE,
        CAUSE_ILLEGAL,
        CAUSE_IRQ
    } trap_cause_e;

endpackage

//--- design/core_controller.sv
module core_controller
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fetch_stage_ready,
    input  logic       exec_stage_ready,
    input  logic       mem_stage_ready,
    input  ctrl_path_e ctrl_path,
    input  logic       exception_valid,
    input  logic       interrupt_valid,
    output logic       fetch_stage_valid,
    output logic       exec_stage_valid,
    output logic       exec_phase,
    output logic       mem_stage_valid,
    output logic       reg_d_en,
    output logic       csr_en,
    output logic       instr_done,
    output logic       check_interrupt
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH_0,
        FETCH_1,
        EXEC_0,
        MEM_0,
        EXEC_1,
        MEM_1
    } state_e;

    state_e state;
    state_e state_next;
    logic   is_mem_op;
    logic   two_phase;

    // Memory ops visit MEM_0, atomics also run EXEC_1 and MEM_1
    assign is_mem_op = (ctrl_path == CTRL_MEM) || (ctrl_path == CTRL_AMO);
    assign two_phase = (ctrl_path == CTRL_AMO);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        if (exception_valid || interrupt_valid) begin
            // Any trap restarts at the first fetch state
            state_next = FETCH_0;
        end else begin
            case (state)
                IDLE:    state_next = FETCH_0;
                FETCH_0: state_next = FETCH_1;
                FETCH_1: if (fetch_stage_ready) state_next = EXEC_0;
                EXEC_0:  if (exec_stage_ready) state_next = is_mem_op ? MEM_0 : FETCH_0;
                MEM_0:   if (mem_stage_ready) state_next = two_phase ? EXEC_1 : FETCH_0;
                EXEC_1:  if (exec_stage_ready) state_next = MEM_1;
                MEM_1:   if (mem_stage_ready) state_next = FETCH_0;
                default: state_next = IDLE;
            endcase
        end
    end

    // Stage strobes follow the state directly
    assign check_interrupt   = (state == FETCH_0);
    assign fetch_stage_valid = ((state == FETCH_0) || (state == FETCH_1)) && !interrupt_valid;
    assign exec_stage_valid  = (state == EXEC_0) || (state == EXEC_1);
    assign mem_stage_valid   = (state == MEM_0) || (state == MEM_1);
    assign exec_phase        = (state == EXEC_1) || (state == MEM_1);

    // Result is written at the end of EXEC_0, or of MEM_0 for memory ops
    assign reg_d_en = !exception_valid &&
                      (is_mem_op ? ((state == MEM_0) && mem_stage_ready)
                                 : ((state == EXEC_0) && exec_stage_ready));

    assign csr_en = exec_stage_valid && exec_stage_ready;

    // Retire on the last phase of the instruction
    always_comb begin
        case (state)
            EXEC_0:  instr_done = exec_stage_ready && !is_mem_op;
            MEM_0:   instr_done = mem_stage_ready && !two_phase;
            MEM_1:   instr_done = mem_stage_ready;
            default: instr_done = 1'b0;
        endcase
        if (exception_valid) begin
            instr_done = 1'b0;
        end
    end

endmodule

//--- design/fetch_stage.sv
`include "core_config.svh"

module fetch_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               fetch_stage_valid,
    input  logic                               instr_done,
    input  logic                               trap_redirect,
    input  logic                               imem_we,
    input  logic [$clog2(`CORE_IMEM_DEPTH)-1:0] imem_addr,
    input  logic [`CORE_XLEN-1:0]              imem_wdata,
    output logic                               fetch_stage_ready,
    output logic [`CORE_XLEN-1:0]              instr,
    output logic [`CORE_XLEN-1:0]              pc
);

    localparam int IA_W = $clog2(`CORE_IMEM_DEPTH);

    logic [`CORE_XLEN-1:0] imem [`CORE_IMEM_DEPTH];
    logic                  second_cycle;

    // Program load port
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (trap_redirect) begin
            pc <= `CORE_XLEN'(`CORE_TRAP_VECTOR);
        end else if (instr_done) begin
            pc <= pc + `CORE_XLEN'(1);
        end
    end

    // Read issued on the second valid cycle, ready one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            second_cycle      <= 1'b0;
            fetch_stage_ready <= 1'b0;
            instr             <= '0;
        end else if (fetch_stage_valid && !fetch_stage_ready) begin
            if (second_cycle) begin
                second_cycle      <= 1'b0;
                fetch_stage_ready <= 1'b1;
                instr             <= imem[pc[IA_W-1:0]];
            end else begin
                second_cycle <= 1'b1;
            end
        end else begin
            fetch_stage_ready <= 1'b0;
        end
    end

endmodule

//--- design/exec_stage.sv
`include "core_config.svh"

module exec_stage
    import core_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [`CORE_XLEN-1:0]             instr,
    input  logic                              exec_stage_valid,
    input  logic                              exec_phase,
    input  logic                              reg_d_en,
    input  logic [`CORE_XLEN-1:0]             mem_rdata,
    input  logic [`CORE_XLEN-1:0]             csr_rdata,
    output logic                              exec_stage_ready,
    output ctrl_path_e                        ctrl_path,
    output logic                              illegal,
    output logic [`CORE_XLEN-1:0]             alu_result,
    output logic [`CORE_XLEN-1:0]             store_data,
    output logic [`CORE_XLEN-1:0]             rd_data,
    output logic [$clog2(`CORE_NREGS)-1:0]    rd_addr,
    output logic [11:0]                       csr_addr
);

    localparam int RA_W = $clog2(`CORE_NREGS);

    opcode_e               opcode;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  writes_rd;
    logic                  is_sll;
    logic [RA_W-1:0]       rs1_addr;
    logic [RA_W-1:0]       rs2_addr;
    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] imm_ext;
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [4:0]            shamt;
    logic [4:0]            sh_cnt;
    logic                  sh_busy;
    logic [`CORE_XLEN-1:0] sh_q;
    logic [`CORE_XLEN-1:0] store_q;
    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    assign opcode   = opcode_e'(instr[31:28]);
    assign rs1_addr = instr[23:20];
    assign rs2_addr = instr[19:16];
    assign imm_ext  = {{(`CORE_XLEN-16){instr[15]}}, instr[15:0]};
    assign shamt    = instr[4:0];
    assign csr_addr = instr[11:0];

    always_comb begin
        ctrl_path = CTRL_EXEC;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        writes_rd = 1'b1;
        illegal   = 1'b0;
        case (opcode)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_ADDI: use_imm = 1'b1;
            OP_SLL:  alu_op = ALU_SLL;
            OP_LW: begin
                ctrl_path = CTRL_MEM;
                use_imm   = 1'b1;
            end
            OP_SW: begin
                ctrl_path = CTRL_MEM;
                use_imm   = 1'b1;
                writes_rd = 1'b0;
            end
            OP_AMOADD: begin
                ctrl_path = CTRL_AMO;
                use_imm   = 1'b1;
            end
            OP_CSRR: alu_op = ALU_PASS;
            OP_CSRW: begin
                alu_op    = ALU_PASS;
                writes_rd = 1'b0;
            end
            default: begin
                illegal   = 1'b1;
                writes_rd = 1'b0;
            end
        endcase
    end

    assign is_sll = (alu_op == ALU_SLL);

    // Register 0 reads as zero and is never written
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (reg_d_en && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Second atomic phase adds the latched rs2 to the loaded word
    assign op_a = exec_phase ? mem_rdata : rs1_val;
    assign op_b = exec_phase ? store_q : (use_imm ? imm_ext : rs2_val);

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = sh_busy ? sh_q : rs1_val;
            default:  alu_result = op_a;
        endcase
    end

    // Shift amount from imm[4:0], one bit per cycle
    always_comb begin
        if (!is_sll) begin
            exec_stage_ready = exec_stage_valid;
        end else if (sh_busy) begin
            exec_stage_ready = exec_stage_valid && (sh_cnt == '0);
        end else begin
            exec_stage_ready = exec_stage_valid && (shamt == '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sh_busy <= 1'b0;
            sh_cnt  <= '0;
        end else if (exec_stage_valid && is_sll) begin
            if (!sh_busy) begin
                sh_busy <= (shamt != '0);
                sh_cnt  <= shamt - 5'd1;
            end else if (sh_cnt == '0) begin
                sh_busy <= 1'b0;
            end else begin
                sh_cnt <= sh_cnt - 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exec_stage_valid && is_sll && !exec_stage_ready) begin
            sh_q <= (sh_busy ? sh_q : rs1_val) << 1;
        end
    end

    // Holds rs2 after phase one and the atomic sum after phase two
    always_ff @(posedge clk) begin
        if (exec_stage_valid && exec_stage_ready) begin
            store_q <= exec_phase ? alu_result : rs2_val;
        end
    end

    assign store_data = store_q;
    assign rd_addr    = writes_rd ? instr[27:24] : '0;

    always_comb begin
        if (opcode == OP_CSRR) begin
            rd_data = csr_rdata;
        end else if (ctrl_path != CTRL_EXEC) begin
            rd_data = mem_rdata;
        end else begin
            rd_data = alu_result;
        end
    end

endmodule

//--- design/mem_stage.sv
`include "core_config.svh"

module mem_stage
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_stage_valid,
    input  logic                  exec_phase,
    input  ctrl_path_e            ctrl_path,
    input  logic                  is_store,
    input  logic [`CORE_XLEN-1:0] addr,
    input  logic [`CORE_XLEN-1:0] wdata,
    output logic                  mem_stage_ready,
    output logic [`CORE_XLEN-1:0] mem_rdata
);

    localparam int DA_W = $clog2(`CORE_DMEM_DEPTH);

    logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_DEPTH];
    logic [DA_W-1:0]       addr_q;
    logic [DA_W-1:0]       waddr;
    logic                  write_op;

    // Stores and the second atomic phase write, everything else reads
    assign write_op = is_store || ((ctrl_path == CTRL_AMO) && exec_phase);

    // Atomic write goes back to the address read in phase one
    assign waddr = exec_phase ? addr_q : addr[DA_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_stage_ready <= 1'b0;
        end else begin
            mem_stage_ready <= mem_stage_valid && !mem_stage_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_stage_valid && mem_stage_ready && write_op) begin
            dmem[waddr] <= wdata;
        end
    end

    // Read data lands with ready and holds until the next read
    always_ff @(posedge clk) begin
        if (mem_stage_valid && !mem_stage_ready && !write_op) begin
            mem_rdata <= dmem[addr[DA_W-1:0]];
            addr_q    <= addr[DA_W-1:0];
        end
    end

endmodule

//--- design/trap_csr.sv
`include "core_config.svh"

module trap_csr
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  exec_stage_valid,
    input  logic                  illegal,
    input  logic                  check_interrupt,
    input  logic                  irq,
    input  logic                  csr_en,
    input  logic                  csr_we,
    input  logic [11:0]           csr_addr,
    input  logic [`CORE_XLEN-1:0] csr_wdata,
    input  logic                  instr_done,
    input  logic [`CORE_XLEN-1:0] pc,
    output logic                  exception_valid,
    output logic                  interrupt_valid,
    output logic                  trap_redirect,
    output logic [`CORE_XLEN-1:0] csr_rdata,
    output logic                  trap_taken,
    output trap_cause_e           trap_cause
);

    logic [`CORE_XLEN-1:0] mstatus;
    logic [`CORE_XLEN-1:0] mepc;
    logic [`CORE_XLEN-1:0] mcause;
    logic [`CORE_XLEN-1:0] minstret;
    trap_cause_e           cause;

    // mstatus bit 0 enables the interrupt
    assign exception_valid = exec_stage_valid && illegal;
    assign interrupt_valid = check_interrupt && irq && mstatus[0];
    assign trap_redirect   = exception_valid || interrupt_valid;

    assign cause = exception_valid ? CAUSE_ILLEGAL :
                   (interrupt_valid ? CAUSE_IRQ : CAUSE_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus    <= '0;
            mepc       <= '0;
            mcause     <= '0;
            minstret   <= '0;
            trap_taken <= 1'b0;
            trap_cause <= CAUSE_NONE;
        end else begin
            trap_taken <= trap_redirect;
            trap_cause <= cause;
            if (instr_done) begin
                minstret <= minstret + `CORE_XLEN'(1);
            end
            if (trap_redirect) begin
                mepc       <= pc;
                mcause     <= `CORE_XLEN'(cause);
                mstatus[0] <= 1'b0;
            end else if (csr_en && csr_we) begin
                case (csr_addr)
                    `CSR_MSTATUS:  mstatus  <= csr_wdata;
                    `CSR_MEPC:     mepc     <= csr_wdata;
                    `CSR_MCAUSE:   mcause   <= csr_wdata;
                    `CSR_MINSTRET: minstret <= csr_wdata;
                    default:       mstatus  <= mstatus;
                endcase
            end
        end
    end

    always_comb begin
        case (csr_addr)
            `CSR_MSTATUS:  csr_rdata = mstatus;
            `CSR_MEPC:     csr_rdata = mepc;
            `CSR_MCAUSE:   csr_rdata = mcause;
            `CSR_MINSTRET: csr_rdata = minstret;
            default:       csr_rdata = '0;
        endcase
    end

endmodule

//--- design/core_top.sv
`include "core_config.svh"

module core_top
    import core_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                irq,
    input  logic                                imem_we,
    input  logic [$clog2(`CORE_IMEM_DEPTH)-1:0] imem_addr,
    input  logic [`CORE_XLEN-1:0]               imem_wdata,
    output logic                                wb_en,
    output logic [$clog2(`CORE_NREGS)-1:0]      wb_addr,
    output logic [`CORE_XLEN-1:0]               wb_data,
    output logic                                retire,
    output logic                                trap_taken,
    output trap_cause_e                         trap_cause
);

    logic                             fetch_stage_valid;
    logic                             fetch_stage_ready;
    logic                             exec_stage_valid;
    logic                             exec_stage_ready;
    logic                             exec_phase;
    logic                             mem_stage_valid;
    logic                             mem_stage_ready;
    logic                             reg_d_en;
    logic                             csr_en;
    logic                             instr_done;
    logic                             check_interrupt;
    logic                             exception_valid;
    logic                             interrupt_valid;
    logic                             trap_redirect;
    logic                             illegal;
    logic                             is_store;
    logic                             csr_we;
    ctrl_path_e                       ctrl_path;
    logic [`CORE_XLEN-1:0]            instr;
    logic [`CORE_XLEN-1:0]            pc;
    logic [`CORE_XLEN-1:0]            alu_result;
    logic [`CORE_XLEN-1:0]            store_data;
    logic [`CORE_XLEN-1:0]            rd_data;
    logic [`CORE_XLEN-1:0]            mem_rdata;
    logic [`CORE_XLEN-1:0]            csr_rdata;
    logic [$clog2(`CORE_NREGS)-1:0]   rd_addr;
    logic [11:0]                      csr_addr;

    assign is_store = (opcode_e'(instr[31:28]) == OP_SW);
    assign csr_we   = (opcode_e'(instr[31:28]) == OP_CSRW);

    core_controller u_ctrl (
        .clk, .rst_n, .fetch_stage_ready, .exec_stage_ready, .mem_stage_ready,
        .ctrl_path, .exception_valid, .interrupt_valid, .fetch_stage_valid,
        .exec_stage_valid, .exec_phase, .mem_stage_valid, .reg_d_en, .csr_en,
        .instr_done, .check_interrupt
    );

    fetch_stage u_fetch (
        .clk, .rst_n, .fetch_stage_valid, .instr_done, .trap_redirect,
        .imem_we, .imem_addr, .imem_wdata, .fetch_stage_ready, .instr, .pc
    );

    exec_stage u_exec (
        .clk, .rst_n, .instr, .exec_stage_valid, .exec_phase, .reg_d_en,
        .mem_rdata, .csr_rdata, .exec_stage_ready, .ctrl_path, .illegal,
        .alu_result, .store_data, .rd_data, .rd_addr, .csr_addr
    );

    mem_stage u_mem (
        .clk, .rst_n, .mem_stage_valid, .exec_phase, .ctrl_path, .is_store,
        .addr(alu_result), .wdata(store_data), .mem_stage_ready, .mem_rdata
    );

    trap_csr u_trap (
        .clk, .rst_n, .exec_stage_valid, .illegal, .check_interrupt, .irq,
        .csr_en, .csr_we, .csr_addr, .csr_wdata(alu_result), .instr_done, .pc,
        .exception_valid, .interrupt_valid, .trap_redirect, .csr_rdata,
        .trap_taken, .trap_cause
    );

    // Same condition as the register file write
    assign wb_en   = reg_d_en && (rd_addr != '0);
    assign wb_addr = rd_addr;
    assign wb_data = rd_data;
    assign retire  = instr_done;

endmodule

//--- verif/core_tb_chk.sv
module core_tb_chk (
    input logic clk,
    input logic rst_n,
    input logic fetch_stage_valid,
    input logic exec_stage_valid,
    input logic mem_stage_valid,
    input logic instr_done,
    input logic reg_d_en,
    input logic exception_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Only one stage may be active in any cycle
    a_one_stage: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({fetch_stage_valid, exec_stage_valid, mem_stage_valid}))
        else $error("more than one stage valid at once");

    // A faulting instruction neither retires nor writes back
    a_no_retire_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_done && exception_valid))
        else $error("instr_done together with exception_valid");

    a_no_write_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_d_en && exception_valid))
        else $error("reg_d_en together with exception_valid");

endmodule

bind core_controller core_tb_chk i_chk (
    .clk(clk),
    .rst_n(rst_n),
    .fetch_stage_valid(fetch_stage_valid),
    .exec_stage_valid(exec_stage_valid),
    .mem_stage_valid(mem_stage_valid),
    .instr_done(instr_done),
    .reg_d_en(reg_d_en),
    .exception_valid(exception_valid)
);

//--- verif/core_tb.sv
`include "core_config.svh"

module core_tb
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Six tests: image load plus reset, then up to 20 instructions of 12 cycles
    localparam int TIMEOUT = 6 * (64 + 8) + 6 * 20 * 12 + 128;

    logic        clk;
    logic        rst_n;
    logic        irq;
    logic        imem_we;
    logic [5:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic        wb_en;
    logic [3:0]  wb_addr;
    logic [31:0] wb_data;
    logic        retire;
    logic        trap_taken;
    trap_cause_e trap_cause;

    int          seed;
    int          errors;
    int          tests;
    int          cycle;
    int          load_ptr;
    logic [31:0] image [64];
    logic [31:0] mregs [16];
    logic [31:0] mmem [64];
    logic [3:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    int          lat_q [$];
    int          retire_q [$];
    trap_cause_e trap_q [$];

    core_top i_dut (
        .clk, .rst_n, .irq, .imem_we, .imem_addr, .imem_wdata,
        .wb_en, .wb_addr, .wb_data, .retire, .trap_taken, .trap_cause
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n      = 1'b0;
        irq        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        cycle      = 0;
        for (int i = 0; i < 16; i++) begin
            mregs[i] = '0;
        end
    end

    // Cycle counter and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout: simulation ran past %0d cycles", TIMEOUT);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (wb_en) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("unexpected write-back to r%0d at %0t", wb_addr, $time);
                end else begin
                    check_reg("wb_addr", wb_addr, exp_addr.pop_front());
                    check_word("wb_data", wb_data, exp_data.pop_front());
                end
            end
            if (retire) begin
                retire_q.push_back(cycle);
            end
            if (trap_taken) begin
                trap_q.push_back(trap_cause);
            end
        end
    end

    task automatic check_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error t=%0t %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic check_reg(input string sig, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error t=%0t %s got r%0d expected r%0d", $time, sig, got, exp);
        end
    endtask

    task automatic check_cause(input string sig, input trap_cause_e got, input trap_cause_e exp);
        if (got !== exp) begin
            errors++;
            $display("error t=%0t %s got %s expected %s", $time, sig, got.name(), exp.name());
        end
    endtask

    task automatic check_cycles(input string sig, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error t=%0t %s got %0d expected %0d", $time, sig, got, exp);
        end
    endtask

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // Place an instruction and step the ISA model
    task automatic emit(input opcode_e op, input logic [3:0] rd, input logic [3:0] rs1,
                        input logic [3:0] rs2, input logic [15:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [5:0]  addr;
        logic        wr;
        int          lat;
        image[load_ptr] = {op, rd, rs1, rs2, imm};
        load_ptr++;
        a    = mregs[rs1];
        b    = mregs[rs2];
        addr = 6'(a + sext16(imm));
        res  = '0;
        wr   = 1'b1;
        lat  = 4;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_ADDI: res = a + sext16(imm);
            OP_SLL: begin
                res = a << imm[4:0];
                lat = 4 + int'(imm[4:0]);
            end
            OP_LW: begin
                res = mmem[addr];
                lat = 6;
            end
            OP_SW: begin
                mmem[addr] = b;
                wr         = 1'b0;
                lat        = 6;
            end
            OP_AMOADD: begin
                res        = mmem[addr];
                mmem[addr] = res + b;
                lat        = 9;
            end
            default: wr = 1'b0;
        endcase
        lat_q.push_back(lat);
        if (wr && (rd != 4'd0)) begin
            mregs[rd] = res;
            exp_addr.push_back(rd);
            exp_data.push_back(res);
        end
    endtask

    task automatic emit_csr_read(input logic [3:0] rd, input logic [11:0] csr,
                                 input logic [31:0] value);
        image[load_ptr] = {OP_CSRR, rd, 8'h00, 4'h0, csr};
        load_ptr++;
        lat_q.push_back(4);
        mregs[rd] = value;
        exp_addr.push_back(rd);
        exp_data.push_back(value);
    endtask

    // Unused words hold illegal opcodes tagged with their address
    task automatic prepare();
        @(negedge clk);
        rst_n = 1'b0;
        irq   = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        lat_q.delete();
        retire_q.delete();
        trap_q.delete();
        for (int i = 0; i < 64; i++) begin
            image[i] = {4'hF, 22'h0, 6'(i)};
        end
        load_ptr = 0;
    endtask

    task automatic run_program(input logic irq_level);
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = 6'(i);
            imem_wdata = image[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (8) @(negedge clk);
        irq   = irq_level;
        rst_n = 1'b1;
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst_n = 1'b0;
        irq   = 1'b0;
        tests++;
    endtask

    task automatic report(input string name, input int err_start);
        if (errors == err_start) begin
            $display("%-12s passed", name);
        end else begin
            $display("%-12s failed with %0d errors", name, errors - err_start);
        end
    endtask

    task automatic expect_no_trap();
        if (trap_q.size() != 0) begin
            errors++;
            $display("a trap was taken although none was expected");
        end
    endtask

    task automatic test_alu();
        int e0;
        e0 = errors;
        prepare();
        emit(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'($random(seed)));
        emit(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'($random(seed)));
        emit(OP_ADD, 4'd3, 4'd1, 4'd2, 16'h0);
        emit(OP_SUB, 4'd4, 4'd1, 4'd2, 16'h0);
        // Result aimed at r0 is dropped and r0 still reads zero
        emit(OP_ADD, 4'd0, 4'd1, 4'd2, 16'h0);
        emit(OP_ADD, 4'd5, 4'd0, 4'd4, 16'h0);
        emit(OP_ADDI, 4'd6, 4'd3, 4'd0, 16'($random(seed)));
        emit(OP_SUB, 4'd7, 4'd6, 4'd1, 16'h0);
        run_program(1'b0);
        expect_no_trap();
        report("alu", e0);
    endtask

    task automatic test_shift();
        int e0;
        int n;
        e0 = errors;
        prepare();
        emit(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'($random(seed)));
        for (int k = 0; k < 4; k++) begin
            n = {$random(seed)} % 13;
            emit(OP_SLL, 4'(k + 2), 4'd1, 4'd0, 16'(n));
        end
        run_program(1'b0);
        if (retire_q.size() < lat_q.size()) begin
            errors++;
            $display("only %0d of %0d instructions retired", retire_q.size(), lat_q.size());
        end else begin
            for (int i = 1; i < lat_q.size(); i++) begin
                check_cycles("retire interval", retire_q[i] - retire_q[i-1], lat_q[i]);
            end
        end
        expect_no_trap();
        report("shift", e0);
    endtask

    task automatic test_store_load();
        int e0;
        e0 = errors;
        prepare();
        emit(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'($random(seed) & 32'h3f));
        emit(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'($random(seed)));
        emit(OP_SW, 4'd0, 4'd1, 4'd2, 16'd3);
        emit(OP_LW, 4'd3, 4'd1, 4'd0, 16'd3);
        run_program(1'b0);
        expect_no_trap();
        report("store_load", e0);
    endtask

    task automatic test_atomic();
        int e0;
        e0 = errors;
        prepare();
        emit(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'($random(seed) & 32'h3f));
        emit(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'($random(seed)));
        emit(OP_SW, 4'd0, 4'd1, 4'd2, 16'd0);
        emit(OP_ADDI, 4'd3, 4'd0, 4'd0, 16'($random(seed)));
        emit(OP_AMOADD, 4'd4, 4'd1, 4'd3, 16'd0);
        emit(OP_LW, 4'd5, 4'd1, 4'd0, 16'd0);
        run_program(1'b0);
        expect_no_trap();
        report("atomic", e0);
    endtask

    task automatic test_illegal();
        int e0;
        e0 = errors;
        prepare();
        emit(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'($random(seed)));
        // Illegal opcode names r7 as its destination
        image[1] = {4'hC, 4'd7, 24'h0};
        load_ptr = `CORE_TRAP_VECTOR;
        emit_csr_read(4'd2, `CSR_MEPC, 32'd1);
        emit_csr_read(4'd3, `CSR_MCAUSE, 32'(CAUSE_ILLEGAL));
        run_program(1'b0);
        if (trap_q.size() != 1) begin
            errors++;
            $display("expected one trap but saw %0d", trap_q.size());
        end else begin
            check_cause("trap_cause", trap_q[0], CAUSE_ILLEGAL);
        end
        report("illegal", e0);
    endtask

    task automatic test_irq();
        int e0;
        e0 = errors;
        prepare();
        emit(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd1);
        emit(OP_CSRW, 4'd0, 4'd1, 4'd0, {4'h0, `CSR_MSTATUS});
        // irq stays high, so the trap hits at the fetch after the enable
        load_ptr = `CORE_TRAP_VECTOR;
        emit_csr_read(4'd5, `CSR_MINSTRET, 32'd2);
        emit_csr_read(4'd6, `CSR_MEPC, 32'd2);
        run_program(1'b1);
        if (trap_q.size() != 1) begin
            errors++;
            $display("expected one interrupt trap but saw %0d", trap_q.size());
        end else begin
            check_cause("trap_cause", trap_q[0], CAUSE_IRQ);
        end
        report("irq", e0);
    endtask

    initial begin
        seed   = 32'h61ca30b0;
        errors = 0;
        tests  = 0;
        test_alu();
        test_shift();
        test_store_load();
        test_atomic();
        test_illegal();
        test_irq();
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/core_pkg.sv
design/core_controller.sv
design/fetch_stage.sv
design/exec_stage.sv
design/mem_stage.sv
design/trap_csr.sv
design/core_top.sv
verif/core_tb_chk.sv
verif/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module core_tb \
    --Mdir obj_dir -o Vcore_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcore_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG" || ! grep -q "Test OK" "$LOG"; then
    exit 1
fi
exit 0
